// File: xform_top.f
+incdir+design
design/xform_pkg.sv
design/xform_stage.sv
design/xform_lane.sv
design/word_history.sv
design/xform_array.sv
design/xform_top.sv
tests/xform_assert.sv
tests/xform_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the word transform engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -j 0 \
	--top-module xform_tb \
	-f xform_top.f \
	-o xform_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/xform_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tests/xform_tb.sv
// ########################################
// testbench for the word transform engine
// table driven, with a reference model
// ########################################

`timescale 1ns/1ps
`default_nettype none

`include "xform_cfg.svh"

module xform_tb;

	import xform_pkg::*;

	localparam int W      = `XF_WIDTH;
	localparam int PERIOD = 8;
	localparam int NROWS  = 6;
	localparam int LAT    = `XF_DEPTH + 1; // capture plus the lane stages
	localparam int HIST   = LAT + `XF_LANES;
	localparam int FLUSH  = `XF_DEPTH;     // edges after reset until the lanes hold real results

	typedef enum int {
		PAT_ZERO,
		PAT_IMPULSE,
		PAT_RAMP,
		PAT_RANDOM,
		PAT_RESET
	} pat_t;

	typedef struct {
		string name;
		int    count;
		pat_t  kind;
		word_t seed;
		bit    end_const; // last word must show the zero fold
	} row_t;

	logic  clk;
	logic  rst;
	word_t din;
	word_t dout;

	row_t  rows [NROWS];
	bit    rows_ready;
	word_t model_hist [HIST]; // newest sampled word first
	int    settle;
	int    n_checks;
	int    n_errors;
	int    n_tests;
	word_t lcg_state;

	xform_top uut (
		.clk (clk),
		.rst (rst),
		.din (din),
		.dout(dout)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	function automatic word_t lcg_next(input word_t s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// whole bytes to the left, count from the low two bits
	function automatic word_t byte_rot(input word_t w);
		word_t r;
		int    n;
		r = w;
		n = int'(w[1:0]);
		for (int k = 0; k < n; k++) begin
			r = {r[W-9:0], r[W-1:W-8]};
		end
		return r;
	endfunction

	// I invert, R byte rotate, G gray, first stage on the left
	function automatic string lane_order(input int c);
		string s;
		case (c)
			0:       s = "IRGGRIR";
			1:       s = "IRGGIRG";
			2:       s = "IIGRIRR";
			3:       s = "RIRGRIG";
			default: s = "IGRGIGR";
		endcase
		return s;
	endfunction

	function automatic word_t lane_chain(input int c, input word_t w);
		string ord;
		word_t v;
		ord = lane_order(c);
		v = w;
		for (int i = 0; i < `XF_DEPTH; i++) begin
			case (ord[i])
				"I":     v = ~v;
				"R":     v = byte_rot(v);
				"G":     v = v ^ (v >> 1);
				default: v = v;
			endcase
		end
		return v;
	endfunction

	function automatic word_t zero_fold();
		word_t acc;
		acc = '0;
		for (int c = 0; c < `XF_LANES; c++) begin
			acc ^= lane_chain(c, '0);
		end
		return acc;
	endfunction

	// lane c shows the word sampled LAT + c edges back
	function automatic word_t expected_dout();
		word_t acc;
		acc = '0;
		for (int c = 0; c < `XF_LANES; c++) begin
			acc ^= lane_chain(c, model_hist[LAT+c]);
		end
		return acc;
	endfunction

	task automatic check_value(input string name, input word_t exp, input word_t act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// drive one word, take the edge, then compare
	task automatic run_cycle(input string name, input word_t w, input logic r);
		din = w;
		rst = r;
		@(posedge clk);
		if (rst) begin
			for (int k = 0; k < HIST; k++) begin
				model_hist[k] = '0;
			end
			settle = 0;
		end else begin
			for (int k = HIST - 1; k > 0; k--) begin
				model_hist[k] = model_hist[k-1];
			end
			model_hist[0] = din;
			settle++;
		end
		#1;
		if (rst) begin
			check_value(name, '0, dout); // every register cleared
		end else if (settle >= FLUSH) begin
			check_value(name, expected_dout(), dout);
		end
	endtask

	task automatic set_row(input int idx, input string name, input int count,
			input pat_t kind, input word_t seed, input bit end_const);
		rows[idx].name      = name;
		rows[idx].count     = count;
		rows[idx].kind      = kind;
		rows[idx].seed      = seed;
		rows[idx].end_const = end_const;
	endtask

	task automatic report_test(input string name, input int c0, input int e0);
		n_tests++;
		$display("test %-16s %4d checks  %0d errors", name, n_checks - c0, n_errors - e0);
	endtask

	initial begin : main
		int    c0;
		int    e0;
		word_t w;
		logic  r;
		din       = '0;
		rst       = 1'b0;
		settle    = 0;
		n_checks  = 0;
		n_errors  = 0;
		n_tests   = 0;
		lcg_state = 32'd4515;
		for (int k = 0; k < HIST; k++) begin
			model_hist[k] = '0;
		end
		set_row(0, "zero_const",  20, PAT_ZERO,    '0,            1'b1);
		set_row(1, "impulse",     20, PAT_IMPULSE, 32'h8000_0103, 1'b1);
		set_row(2, "ramp",        40, PAT_RAMP,    32'hffff_fff0, 1'b0);
		set_row(3, "random",      60, PAT_RANDOM,  '0,            1'b0);
		set_row(4, "reset_pulse", 16, PAT_RESET,   32'h5a5a_0001, 1'b1);
		set_row(5, "restart",     30, PAT_RANDOM,  '0,            1'b0);
		rows_ready = 1'b1;
		#1;

		c0 = n_checks;
		e0 = n_errors;
		repeat (5) run_cycle("power_on_reset", '0, 1'b1);
		report_test("power_on_reset", c0, e0);

		for (int k = 0; k < NROWS; k++) begin
			c0 = n_checks;
			e0 = n_errors;
			for (int i = 0; i < rows[k].count; i++) begin
				r = 1'b0;
				case (rows[k].kind)
					PAT_IMPULSE: w = (i == 0) ? rows[k].seed : '0;
					PAT_RAMP:    w = rows[k].seed + word_t'(i);
					PAT_RANDOM: begin
						lcg_state = lcg_next(lcg_state);
						w = lcg_state;
					end
					PAT_RESET: begin
						if (i < 2) begin
							r = 1'b1;
							w = rows[k].seed + word_t'(i); // traffic under reset
						end else begin
							w = '0;
						end
					end
					default: w = '0;
				endcase
				run_cycle(rows[k].name, w, r);
				if (rows[k].end_const && i == rows[k].count - 1) begin
					check_value(rows[k].name, zero_fold(), dout);
				end
			end
			report_test(rows[k].name, c0, e0);
		end

		$display("done: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		int total;
		wait (rows_ready);
		total = 0;
		for (int k = 0; k < NROWS; k++) begin
			total += rows[k].count;
		end
		#((total + 20) * PERIOD);
		$display("watchdog: run still going after %0d clock periods, stopped", total + 20);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/xform_assert.sv
// ########################################
// bound checks on reset and history shift
// ########################################

`timescale 1ns/1ps
`default_nettype none

`include "xform_cfg.svh"

module xform_assert #(
	parameter int SLOTS = 1
) (
	input logic                         clk,
	input logic                         rst,
	input logic [SLOTS*`XF_WIDTH-1:0]   regs
);

	localparam int W = `XF_WIDTH;

	// cleared while reset is held
	a_reset_zero: assert property (@(posedge clk) rst |-> regs == '0)
		else $error("register holds a nonzero value during reset");

	// slot i takes slot i-1 one cycle later
	for (genvar i = 1; i < SLOTS; i++) begin : g_shift
		a_shift: assert property (
			@(posedge clk) disable iff (rst)
			!$past(rst) |-> regs[i*W +: W] == $past(regs[(i-1)*W +: W])
		) else $error("slot %0d did not take the value of slot %0d", i, i - 1);
	end

endmodule

bind word_history xform_assert #(
	.SLOTS(`XF_LANES)
) history_chk (
	.clk (clk),
	.rst (rst),
	.regs(lanes)
);

bind xform_stage xform_assert #(
	.SLOTS(1)
) stage_chk (
	.clk (clk),
	.rst (rst),
	.regs(dout)
);

`default_nettype wire

// File: design/xform_top.sv
// ########################################
// word transform engine top level
// ########################################

`timescale 1ns/1ps
`default_nettype none

module xform_top (
	input  logic             clk,
	input  logic             rst,
	input  xform_pkg::word_t din,
	output xform_pkg::word_t dout
);

	import xform_pkg::*;

	// captured history, newest word in l0
	lane_words_t lanes;

	word_history history_i (
		.clk  (clk),
		.rst  (rst),
		.din  (din),
		.lanes(lanes)
	);

	// 7 stage lanes, dout lags din by 8 to 12 cycles per lane
	xform_array array_i (
		.clk  (clk),
		.rst  (rst),
		.lanes(lanes),
		.dout (dout)
	);

endmodule

`default_nettype wire

// File: design/xform_array.sv
// ########################################
// five transform lanes and the xor fold
// of their results into one word
// ########################################

`timescale 1ns/1ps
`default_nettype none

`include "xform_cfg.svh"

module xform_array (
	input  logic                    clk,
	input  logic                    rst,
	input  xform_pkg::lane_words_t  lanes,
	output xform_pkg::word_t        dout
);

	import xform_pkg::*;

	// stage order per lane, first stage listed first
	localparam chain_t LANE_ORDER [`XF_LANES] = '{
		'{OP_INV, OP_ROT, OP_GRAY, OP_GRAY, OP_ROT, OP_INV, OP_ROT},  // lane 0
		'{OP_INV, OP_ROT, OP_GRAY, OP_GRAY, OP_INV, OP_ROT, OP_GRAY}, // lane 1
		'{OP_INV, OP_INV, OP_GRAY, OP_ROT, OP_INV, OP_ROT, OP_ROT},   // lane 2
		'{OP_ROT, OP_INV, OP_ROT, OP_GRAY, OP_ROT, OP_INV, OP_GRAY},  // lane 3
		'{OP_INV, OP_GRAY, OP_ROT, OP_GRAY, OP_INV, OP_GRAY, OP_ROT}  // lane 4
	};

	word_t lane_in  [`XF_LANES];
	word_t lane_out [`XF_LANES];

	// lane c gets the word taken c cycles before the newest
	assign lane_in[0] = lanes.l0;
	assign lane_in[1] = lanes.l1;
	assign lane_in[2] = lanes.l2;
	assign lane_in[3] = lanes.l3;
	assign lane_in[4] = lanes.l4;

	for (genvar c = 0; c < `XF_LANES; c++) begin : g_lane
		xform_lane #(
			.ORDER(LANE_ORDER[c])
		) lane_i (
			.clk (clk),
			.rst (rst),
			.din (lane_in[c]),
			.dout(lane_out[c])
		);
	end

	// fold of the lane results, no register after the lanes
	always_comb begin
		dout = '0;
		for (int c = 0; c < `XF_LANES; c++) begin
			dout ^= lane_out[c];
		end
	end

endmodule

`default_nettype wire

// File: design/word_history.sv
// ########################################
// input word history and capture register
// feeds one word per lane each cycle
// ########################################

`timescale 1ns/1ps
`default_nettype none

`include "xform_cfg.svh"

module word_history (
	input  logic                    clk,
	input  logic                    rst,
	input  xform_pkg::word_t        din,
	output xform_pkg::lane_words_t  lanes
);

	import xform_pkg::*;

	// hist[0] is the newest word, hist[XF_LANES-1] the oldest
	word_t hist [`XF_LANES];

	// shift history, din enters at the newest end
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `XF_LANES; i++) begin
				hist[i] <= '0;
			end
		end else begin
			hist[0] <= din;
			for (int i = 1; i < `XF_LANES; i++) begin
				hist[i] <= hist[i-1];
			end
		end
	end

	// snapshot of the whole history, one cycle behind the shift
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lanes <= '0;
		end else begin
			lanes <= '{
				l0: hist[0],
				l1: hist[1],
				l2: hist[2],
				l3: hist[3],
				l4: hist[4]
			};
		end
	end

endmodule

`default_nettype wire

// File: design/xform_lane.sv
// ########################################
// one lane of chained transform stages
// order of kinds given by ORDER
// ########################################

`timescale 1ns/1ps
`default_nettype none

`include "xform_cfg.svh"

module xform_lane #(
	parameter xform_pkg::chain_t ORDER = '{default: xform_pkg::OP_INV}
) (
	input  logic             clk,
	input  logic             rst,
	input  xform_pkg::word_t din,
	output xform_pkg::word_t dout
);

	import xform_pkg::*;

	// link[i] is the input of stage i
	// the last entry is the lane result
	word_t link [`XF_DEPTH+1];

	assign link[0] = din;

	// one cycle per stage, XF_DEPTH cycles through the lane
	for (genvar i = 0; i < `XF_DEPTH; i++) begin : g_stage
		xform_stage #(
			.KIND(ORDER[i])
		) stage_i (
			.clk (clk),
			.rst (rst),
			.din (link[i]),
			.dout(link[i+1])
		);
	end

	assign dout = link[`XF_DEPTH];

endmodule

`default_nettype wire

// File: design/xform_stage.sv
// ########################################
// one registered transform step
// kind fixed at build time by KIND
// ########################################

`timescale 1ns/1ps
`default_nettype none

`include "xform_cfg.svh"

module xform_stage #(
	parameter xform_pkg::stage_kind_t KIND = xform_pkg::OP_INV
) (
	input  logic             clk,
	input  logic             rst,
	input  xform_pkg::word_t din,
	output xform_pkg::word_t dout
);

	import xform_pkg::*;

	localparam int W = `XF_WIDTH;

	logic [4:0]     rot_amt;
	logic [2*W-1:0] rot_dbl;
	word_t          rot_w;
	word_t          gray_w;
	word_t          nxt;

	// rotate by whole bytes, amount from the low two bits
	assign rot_amt = {din[1:0], 3'b000}; // 0, 8, 16 or 24
	assign rot_dbl = {din, din} << rot_amt;
	assign rot_w   = rot_dbl[2*W-1:W]; // upper half is the rotated word

	assign gray_w = din ^ (din >> 1);

	always_comb begin
		case (KIND)
			OP_INV:  nxt = ~din;
			OP_ROT:  nxt = rot_w;
			OP_GRAY: nxt = gray_w;
			default: nxt = din;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dout <= '0;
		end else begin
			dout <= nxt;
		end
	end

endmodule

`default_nettype wire

// File: design/xform_pkg.sv
// ########################################
// word transform engine types
// ########################################

`default_nettype none

`include "xform_cfg.svh"

package xform_pkg;

	// one data word, used on every data path
	typedef logic [`XF_WIDTH-1:0] word_t;

	// what a single stage does to its word
	typedef enum logic [1:0] {
		OP_INV  = 2'd0, // bitwise complement
		OP_ROT  = 2'd1, // byte rotate left
		OP_GRAY = 2'd2  // binary to gray
	} stage_kind_t;

	// stage kinds of one lane
	// element 0 is the first stage the word passes
	typedef stage_kind_t [0:`XF_DEPTH-1] chain_t;

	// captured history, one word per lane
	typedef struct packed {
		word_t l4; // oldest word
		word_t l3;
		word_t l2;
		word_t l1;
		word_t l0; // newest word
	} lane_words_t;

endpackage

`default_nettype wire

// File: design/xform_cfg.svh
// ########################################
// word transform engine configuration
// sizes shared by the package and the RTL
// ########################################

`ifndef XFORM_CFG_SVH
`define XFORM_CFG_SVH

// data word width in bits
`define XF_WIDTH 32

// number of parallel lanes, one per history slot
`define XF_LANES 5

// registered stages in each lane
`define XF_DEPTH 7

`endif
